// ==== design/nimPkg.sv ====
`default_nettype none

package nimPkg;

   typedef logic [7:0]  byte_t;
   typedef logic [35:0] regAddr_t;
   typedef logic [63:0] regData_t;
   typedef logic [31:0] crc_t;
   typedef logic [7:0]  nimIn_t;
   typedef logic [7:0]  chanMask_t;
   typedef logic [7:0]  count_t;

   typedef enum logic [2:0] {stIdle, stPreamble, stBody, stFcs, stDrop} rxState_t;
   typedef enum logic [7:0] {opRead = 8'd0, opWrite = 8'd1} otsOp_t;
   typedef enum logic {modeOr = 1'b0, modeAnd = 1'b1} chanMode_t;

   // frame length after the start-of-frame byte
   localparam int FRAME_BYTES = 60;
   localparam int FCS_BYTES   = 4;

   localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
   localparam byte_t       PROTO_UDP      = 8'h11;
   localparam crc_t        CRC_INIT       = 32'hffff_ffff;

   // register map
   localparam int ADDR_GLOBAL    = 0;
   localparam int ADDR_CHAN_BASE = 16;

   // global register fields
   localparam int GLB_EN_LSB  = 0;
   localparam int GLB_INV_LSB = 4;

   // channel register fields
   localparam int CFG_MASK_LSB    = 0;
   localparam int CFG_MODE_BIT    = 8;
   localparam int CFG_DELAY_LSB   = 16;
   localparam int CFG_STRETCH_LSB = 24;

   // ethernet crc32, one byte per call, data lsb first
   function automatic crc_t nextCrc(crc_t crc, byte_t d);
      crc_t c;
      logic fb;
      c = crc;
      for (int i = 0; i < 8; i++)
      begin
         fb = c[31] ^ d[i];
         c  = {c[30:0], 1'b0} ^ (fb ? 32'h04c1_1db7 : 32'h0);
      end
      return c;
   endfunction

endpackage

`default_nettype wire

// ==== design/chanCfgIf.sv ====
`timescale 1ns/1ps
`default_nettype none

// one trigger channel's settings, all static levels
interface chanCfgIf
   import nimPkg::*;
();

   chanMask_t mask;
   chanMode_t mode;
   count_t    delay;
   count_t    stretch;

   modport cfgSrc  (output mask, output mode, output delay, output stretch);
   modport cfgSink (input mask, input mode, input delay, input stretch);

endinterface

`default_nettype wire

// ==== design/ethRxParser.sv ====
`timescale 1ns/1ps
`default_nettype none

module ethRxParser
   import nimPkg::*;
#(
   parameter logic [47:0] OUR_MAC  = 48'h008055ec0078,
   parameter logic [15:0] UDP_PORT = 16'h07d7
)
(
   input  wire             PHY_RXCLK,
   input  wire             rst,
   input  wire byte_t      PHY_RXD,
   input  wire             PHY_RXCTL_RXDV,
   input  wire             PHY_RXER,
   output logic            wrEn,
   output regAddr_t        wrAddr,
   output regData_t        wrData
);

   // byte offsets after the start-of-frame byte
   localparam int OFS_ETYPE = 12;
   localparam int OFS_PROTO = 23;
   localparam int OFS_DPORT = 36;
   localparam int OFS_FLAGS = 42;
   localparam int OFS_COUNT = 43;
   localparam int OFS_ADDR  = 44;

   rxState_t   state;
   logic [5:0] byteCnt;
   crc_t       crc;
   crc_t       fcsExp;
   byte_t      fcsByte;
   byte_t      expByte;
   logic       checkByte;
   logic [5:0] payOfs;

   // expected value of the checked header bytes
   always_comb
   begin
      expByte   = 8'h00;
      checkByte = 1'b1;
      if (byteCnt < 6'd6)
         expByte = OUR_MAC[8 * (5 - byteCnt) +: 8];
      else
      begin
         case (byteCnt)
            6'(OFS_ETYPE):     expByte = ETHERTYPE_IPV4[15:8];
            6'(OFS_ETYPE + 1): expByte = ETHERTYPE_IPV4[7:0];
            6'(OFS_PROTO):     expByte = PROTO_UDP;
            6'(OFS_DPORT):     expByte = UDP_PORT[15:8];
            6'(OFS_DPORT + 1): expByte = UDP_PORT[7:0];
            6'(OFS_FLAGS):     expByte = opWrite;
            6'(OFS_COUNT):     expByte = 8'd1;
            default:           checkByte = 1'b0;
         endcase
      end
   end

   // fcs on the wire is the inverted, bit-reversed crc, low byte first
   always_comb
   begin
      for (int i = 0; i < 32; i++)
         fcsExp[i] = ~crc[31 - i];
   end

   assign fcsByte = fcsExp[8 * byteCnt[1:0] +: 8];

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         state   <= stIdle;
         byteCnt <= '0;
         crc     <= CRC_INIT;
         wrEn    <= 1'b0;
      end
      else
      begin
         wrEn <= 1'b0;
         case (state)
            stIdle:
               if (PHY_RXCTL_RXDV)
                  state <= (!PHY_RXER && PHY_RXD == 8'h55) ? stPreamble : stDrop;
            stPreamble:
               if (!PHY_RXCTL_RXDV)
                  state <= stIdle;
               else if (PHY_RXER)
                  state <= stDrop;
               else if (PHY_RXD == 8'hd5)
               begin
                  state   <= stBody;
                  byteCnt <= '0;
                  crc     <= CRC_INIT;
               end
               else if (PHY_RXD != 8'h55)
                  state <= stDrop;
            stBody:
               if (!PHY_RXCTL_RXDV)
                  state <= stIdle;
               else if (PHY_RXER || (checkByte && PHY_RXD != expByte))
                  state <= stDrop;
               else
               begin
                  crc <= nextCrc(crc, PHY_RXD);
                  if (byteCnt == 6'(FRAME_BYTES - 1))
                  begin
                     byteCnt <= '0;
                     state   <= stFcs;
                  end
                  else
                     byteCnt <= byteCnt + 6'd1;
               end
            stFcs:
               // all fcs bytes matched, data-valid has to drop now
               if (byteCnt == 6'(FCS_BYTES))
               begin
                  if (!PHY_RXCTL_RXDV)
                  begin
                     wrEn  <= 1'b1;
                     state <= stIdle;
                  end
                  else
                     state <= stDrop;
               end
               else if (!PHY_RXCTL_RXDV)
                  state <= stIdle;
               else if (PHY_RXER || PHY_RXD != fcsByte)
                  state <= stDrop;
               else
                  byteCnt <= byteCnt + 6'd1;
            stDrop:
               if (!PHY_RXCTL_RXDV)
                  state <= stIdle;
            default:
               state <= stIdle;
         endcase
      end
   end

   // address then data, both least significant byte first
   assign payOfs = byteCnt - 6'(OFS_ADDR);

   always_ff @(posedge PHY_RXCLK)
   begin
      if (state == stBody && PHY_RXCTL_RXDV)
      begin
         if (payOfs < 6'd4)
            wrAddr[8 * payOfs[1:0] +: 8] <= PHY_RXD;
         else if (payOfs == 6'd4)
            wrAddr[35:32] <= PHY_RXD[3:0];
         if (payOfs[5:3] == 3'd1)
            wrData[8 * payOfs[2:0] +: 8] <= PHY_RXD;
      end
   end

endmodule

`default_nettype wire

// ==== design/cfgRegs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfgRegs
   import nimPkg::*;
#(
   parameter int NUM_CHANNELS = 4
)
(
   input  wire                     PHY_RXCLK,
   input  wire                     rst,
   input  wire                     wrEn,
   input  wire regAddr_t           wrAddr,
   input  wire regData_t           wrData,
   output logic [NUM_CHANNELS-1:0] outEnable,
   output logic [NUM_CHANNELS-1:0] outInvert,
   chanCfgIf.cfgSrc                chanCfg [NUM_CHANNELS]
);

   chanMask_t maskReg    [NUM_CHANNELS];
   chanMode_t modeReg    [NUM_CHANNELS];
   count_t    delayReg   [NUM_CHANNELS];
   count_t    stretchReg [NUM_CHANNELS];

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         outEnable <= '0;
         outInvert <= '0;
         for (int c = 0; c < NUM_CHANNELS; c++)
         begin
            maskReg[c]    <= '0;
            modeReg[c]    <= modeOr;
            delayReg[c]   <= '0;
            stretchReg[c] <= '0;
         end
      end
      else if (wrEn)
      begin
         if (wrAddr == regAddr_t'(ADDR_GLOBAL))
         begin
            outEnable <= wrData[GLB_EN_LSB +: NUM_CHANNELS];
            outInvert <= wrData[GLB_INV_LSB +: NUM_CHANNELS];
         end
         // other unmapped addresses fall through untouched
         for (int c = 0; c < NUM_CHANNELS; c++)
         begin
            if (wrAddr == regAddr_t'(ADDR_CHAN_BASE + c))
            begin
               maskReg[c]    <= wrData[CFG_MASK_LSB +: 8];
               modeReg[c]    <= chanMode_t'(wrData[CFG_MODE_BIT]);
               delayReg[c]   <= wrData[CFG_DELAY_LSB +: 8];
               stretchReg[c] <= wrData[CFG_STRETCH_LSB +: 8];
            end
         end
      end
   end

   for (genvar c = 0; c < NUM_CHANNELS; c++)
   begin : gCfg
      assign chanCfg[c].mask    = maskReg[c];
      assign chanCfg[c].mode    = modeReg[c];
      assign chanCfg[c].delay   = delayReg[c];
      assign chanCfg[c].stretch = stretchReg[c];
   end

endmodule

`default_nettype wire

// ==== design/triggerChannel.sv ====
`timescale 1ns/1ps
`default_nettype none

module triggerChannel
   import nimPkg::*;
(
   input  wire         PHY_RXCLK,
   input  wire         rst,
   input  wire nimIn_t nimIn,
   chanCfgIf.cfgSink   cfg,
   output logic        pulse
);

   typedef enum logic [1:0] {chIdle, chDelay, chStretch} chState_t;

   chState_t chState;
   count_t   cnt;
   logic     cond;
   logic     condPrev;
   logic     rise;

   // masked coincidence, an empty mask never fires
   always_comb
   begin
      if (cfg.mask == '0)
         cond = 1'b0;
      else if (cfg.mode == modeAnd)
         cond = &(nimIn | ~cfg.mask);
      else
         cond = |(nimIn & cfg.mask);
   end

   assign rise = cond && !condPrev;

   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
      begin
         chState  <= chIdle;
         cnt      <= '0;
         condPrev <= 1'b0;
      end
      else
      begin
         condPrev <= cond;
         case (chState)
            chIdle:
               // new rises only count here
               if (rise)
               begin
                  chState <= chDelay;
                  cnt     <= cfg.delay;
               end
            chDelay:
               if (cnt == '0)
               begin
                  chState <= chStretch;
                  cnt     <= cfg.stretch;
               end
               else
                  cnt <= cnt - 8'd1;
            chStretch:
               if (cnt == '0)
                  chState <= chIdle;
               else
                  cnt <= cnt - 8'd1;
            default:
               chState <= chIdle;
         endcase
      end
   end

   // high for stretch+1 cycles
   assign pulse = (chState == chStretch);

endmodule

`default_nettype wire

// ==== design/nimOutputStage.sv ====
`timescale 1ns/1ps
`default_nettype none

module nimOutputStage
#(
   parameter int NUM_CHANNELS = 4
)
(
   input  wire                     PHY_RXCLK,
   input  wire                     rst,
   input  wire [NUM_CHANNELS-1:0]  pulse,
   input  wire [NUM_CHANNELS-1:0]  outEnable,
   input  wire [NUM_CHANNELS-1:0]  outInvert,
   output logic [NUM_CHANNELS-1:0] nimOut
);

   // a disabled output rests at its inversion level
   always_ff @(posedge PHY_RXCLK)
   begin
      if (rst)
         nimOut <= '0;
      else
         nimOut <= (pulse & outEnable) ^ outInvert;
   end

endmodule

`default_nettype wire

// ==== design/nimTrigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module nimTrigger
   import nimPkg::*;
#(
   parameter int          NUM_CHANNELS = 4,
   parameter logic [47:0] OUR_MAC      = 48'h008055ec0078,
   parameter logic [15:0] UDP_PORT     = 16'h07d7
)
(
   input  wire                     PHY_RXCLK,
   input  wire                     rst,
   input  wire byte_t              PHY_RXD,
   input  wire                     PHY_RXCTL_RXDV,
   input  wire                     PHY_RXER,
   input  wire nimIn_t             nimIn,
   output logic [NUM_CHANNELS-1:0] nimOut
);

   logic                    wrEn;
   regAddr_t                wrAddr;
   regData_t                wrData;
   logic [NUM_CHANNELS-1:0] outEnable;
   logic [NUM_CHANNELS-1:0] outInvert;
   logic [NUM_CHANNELS-1:0] pulse;

   chanCfgIf chanCfg [NUM_CHANNELS] ();

   ethRxParser #(
      .OUR_MAC  (OUR_MAC),
      .UDP_PORT (UDP_PORT)
   ) i_ethRxParser (
      .PHY_RXCLK      (PHY_RXCLK),
      .rst            (rst),
      .PHY_RXD        (PHY_RXD),
      .PHY_RXCTL_RXDV (PHY_RXCTL_RXDV),
      .PHY_RXER       (PHY_RXER),
      .wrEn           (wrEn),
      .wrAddr         (wrAddr),
      .wrData         (wrData)
   );

   cfgRegs #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) i_cfgRegs (
      .PHY_RXCLK (PHY_RXCLK),
      .rst       (rst),
      .wrEn      (wrEn),
      .wrAddr    (wrAddr),
      .wrData    (wrData),
      .outEnable (outEnable),
      .outInvert (outInvert),
      .chanCfg   (chanCfg)
   );

   // one trigger channel per nim output
   for (genvar c = 0; c < NUM_CHANNELS; c++)
   begin : gChan
      triggerChannel i_triggerChannel (
         .PHY_RXCLK (PHY_RXCLK),
         .rst       (rst),
         .nimIn     (nimIn),
         .cfg       (chanCfg[c]),
         .pulse     (pulse[c])
      );
   end

   nimOutputStage #(
      .NUM_CHANNELS (NUM_CHANNELS)
   ) i_nimOutputStage (
      .PHY_RXCLK (PHY_RXCLK),
      .rst       (rst),
      .pulse     (pulse),
      .outEnable (outEnable),
      .outInvert (outInvert),
      .nimOut    (nimOut)
   );

endmodule

`default_nettype wire

// ==== testbench/nimTrigger_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module nimTrigger_asserts
#(
   parameter int NUM_CHANNELS = 4
)
(
   input wire                    PHY_RXCLK,
   input wire                    rst,
   input wire                    wrEn,
   input wire                    rxDv,
   input wire [NUM_CHANNELS-1:0] nimOut
);

   // write strobe lasts one cycle
   wrEnSingle: assert property (@(posedge PHY_RXCLK) disable iff (rst) wrEn |=> !wrEn)
      else $error("write strobe stayed high for two cycles");

   // writes only follow the end of a frame
   wrEnIdleLine: assert property (@(posedge PHY_RXCLK) disable iff (rst) wrEn |-> !rxDv)
      else $error("write strobe while data-valid is high");

   outAfterReset: assert property (@(posedge PHY_RXCLK) $fell(rst) |-> nimOut == '0)
      else $error("nimOut not zero in the cycle after reset");

endmodule

`default_nettype wire

// ==== testbench/tbNimTrigger.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbNimTrigger
   import nimPkg::*;
();

   localparam int          NCH  = 4;
   localparam logic [47:0] MAC  = 48'h0080_55ec_0078;
   localparam logic [15:0] PORT = 16'h07d7;

   typedef enum {bNone, bFcs, bMac, bPort, bFlag, bRxer} corrupt_t;

   typedef struct {
      string    name;
      regAddr_t addr;
      regData_t data;
      corrupt_t bad;
      int       chan;
      nimIn_t   pattern;
      logic     retrig;
      int       expStart;
      int       expLen;
      logic     expIdle;
   } row_t;

   logic           PHY_RXCLK;
   logic           rst;
   byte_t          PHY_RXD;
   logic           PHY_RXCTL_RXDV;
   logic           PHY_RXER;
   nimIn_t         nimIn;
   logic [NCH-1:0] nimOut;

   row_t        rows[$];
   int          errCount;
   logic [31:0] lcgState;

   nimTrigger #(
      .NUM_CHANNELS (NCH),
      .OUR_MAC      (MAC),
      .UDP_PORT     (PORT)
   ) i_nimTrigger (
      .PHY_RXCLK      (PHY_RXCLK),
      .rst            (rst),
      .PHY_RXD        (PHY_RXD),
      .PHY_RXCTL_RXDV (PHY_RXCTL_RXDV),
      .PHY_RXER       (PHY_RXER),
      .nimIn          (nimIn),
      .nimOut         (nimOut)
   );

   bind nimTrigger nimTrigger_asserts #(.NUM_CHANNELS(NUM_CHANNELS)) i_nimTrigger_asserts (
      .PHY_RXCLK (PHY_RXCLK),
      .rst       (rst),
      .wrEn      (wrEn),
      .rxDv      (PHY_RXCTL_RXDV),
      .nimOut    (nimOut)
   );

   initial
   begin
      PHY_RXCLK = 1'b0;
      forever #2 PHY_RXCLK = ~PHY_RXCLK;
   end

   function automatic logic [31:0] randWord();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // reflected crc32 update by one byte
   function automatic crc_t crcStep(crc_t crc, byte_t b);
      crc_t c;
      c = crc ^ {24'h0, b};
      for (int i = 0; i < 8; i++)
         c = c[0] ? ((c >> 1) ^ 32'hedb8_8320) : (c >> 1);
      return c;
   endfunction

   function automatic regData_t chanWord(chanMask_t mask, chanMode_t mode,
                                         count_t dly, count_t str);
      return {32'h0, str, dly, 7'h0, mode, mask};
   endfunction

   // data bits that the register map ignores
   function automatic regData_t unusedBits(regAddr_t a);
      if (a == 36'(ADDR_GLOBAL))
         return 64'hffff_ffff_ffff_ff00;
      else if (a >= 36'(ADDR_CHAN_BASE) && a < 36'(ADDR_CHAN_BASE + NCH))
         return 64'hffff_ffff_0000_fe00;
      return '1;
   endfunction

   task automatic checkNimOut(string name, logic [NCH-1:0] exp, logic [NCH-1:0] act);
      if (act !== exp)
      begin
         errCount++;
         $display("ERR %s nimOut expected %b actual %b", name, exp, act);
      end
   endtask

   task automatic checkPulseLen(string name, count_t exp, count_t act);
      if (act !== exp)
      begin
         errCount++;
         $display("ERR %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic driveByte(byte_t b, logic dv, logic er);
      @(posedge PHY_RXCLK);
      #1;
      PHY_RXD        = b;
      PHY_RXCTL_RXDV = dv;
      PHY_RXER       = er;
   endtask

   task automatic sendFrame(regAddr_t addr, regData_t data, corrupt_t bad);
      byte_t       fr [FRAME_BYTES + FCS_BYTES];
      crc_t        crc;
      crc_t        fcs;
      logic [63:0] a64;
      a64 = 64'(addr);
      crc = CRC_INIT;
      for (int i = 0; i < FRAME_BYTES; i++)
         fr[i] = 8'(i);
      for (int i = 0; i < 6; i++)
         fr[i] = MAC[8 * (5 - i) +: 8];
      fr[12] = ETHERTYPE_IPV4[15:8];
      fr[13] = ETHERTYPE_IPV4[7:0];
      fr[14] = 8'h45;
      fr[23] = PROTO_UDP;
      fr[36] = PORT[15:8];
      fr[37] = PORT[7:0];
      fr[42] = opWrite;
      fr[43] = 8'd1;
      for (int i = 0; i < 8; i++)
      begin
         fr[44 + i] = a64[8 * i +: 8];
         fr[52 + i] = data[8 * i +: 8];
      end
      if (bad == bMac)
         fr[0] = fr[0] ^ 8'h01;
      if (bad == bPort)
         fr[37] = fr[37] ^ 8'h01;
      if (bad == bFlag)
         fr[42] = opRead;
      for (int i = 0; i < FRAME_BYTES; i++)
         crc = crcStep(crc, fr[i]);
      fcs = ~crc;
      for (int i = 0; i < FCS_BYTES; i++)
         fr[FRAME_BYTES + i] = fcs[8 * i +: 8];
      if (bad == bFcs)
         fr[61] = fr[61] ^ 8'h80;
      for (int i = 0; i < 7; i++)
         driveByte(8'h55, 1'b1, 1'b0);
      driveByte(8'hd5, 1'b1, 1'b0);
      for (int i = 0; i < FRAME_BYTES + FCS_BYTES; i++)
         driveByte(fr[i], 1'b1, bad == bRxer && i == 30);
      driveByte(8'h00, 1'b0, 1'b0);
   endtask

   task automatic runRow(row_t r);
      logic [NCH-1:0] bitSel;
      logic [NCH-1:0] idleVec;
      logic           act;
      count_t         startAt;
      count_t         len;
      int             win;
      bitSel  = NCH'(1) << r.chan;
      idleVec = r.expIdle ? bitSel : '0;
      win     = r.expStart + r.expLen + 10;
      startAt = '0;
      len     = '0;
      sendFrame(r.addr, r.data | ({randWord(), randWord()} & unusedBits(r.addr)), r.bad);
      repeat (20) @(posedge PHY_RXCLK);
      #1;
      nimIn = r.pattern;
      // offset n is sampled just after edge k+n
      for (int n = 0; n <= win; n++)
      begin
         @(posedge PHY_RXCLK);
         #1;
         act = (nimOut[r.chan] != r.expIdle);
         if (n == 0)
            checkNimOut(r.name, idleVec, nimOut & bitSel);
         if (act && len == 0)
            startAt = count_t'(n);
         if (act)
            len++;
         // extra rises while the channel is still busy
         if (r.retrig && n >= 1 && n <= r.expStart + r.expLen - 3)
            nimIn = n[0] ? 8'h00 : r.pattern;
      end
      checkNimOut(r.name, idleVec, nimOut & bitSel);
      checkPulseLen({r.name, " length"}, count_t'(r.expLen), len);
      if (r.expLen > 0)
         checkPulseLen({r.name, " start"}, count_t'(r.expStart), startAt);
      nimIn = '0;
   endtask

   task automatic addRow(string name, regAddr_t addr, regData_t data, corrupt_t bad, int chan,
                         nimIn_t pattern, logic retrig, int expStart, int expLen,
                         logic expIdle);
      row_t r;
      r = '{name, addr, data, bad, chan, pattern, retrig, expStart, expLen, expIdle};
      rows.push_back(r);
   endtask

   // expected start is delay+2 and length is stretch+1 or 0
   task automatic buildTable();
      addRow("emptyMask", 36'd0, 64'h0f, bNone,
             0, 8'hff, 1'b0, 2, 0, 1'b0);
      // long stretch so a stray and-mode fire still covers the first sample
      addRow("emptyMaskAnd", 36'd16, chanWord(8'h00, modeAnd, 8'd1, 8'd40), bNone,
             0, 8'hff, 1'b0, 3, 0, 1'b0);
      addRow("ch0Or", 36'd16, chanWord(8'h03, modeOr, 8'd3, 8'd4), bNone,
             0, 8'h02, 1'b0, 5, 5, 1'b0);
      addRow("ch0AndPart", 36'd16, chanWord(8'h0c, modeAnd, 8'd2, 8'd1), bNone,
             0, 8'h04, 1'b0, 4, 0, 1'b0);
      addRow("unmapped", 36'h8_0000_0010, chanWord(8'hff, modeOr, 8'd9, 8'd9), bNone,
             0, 8'h5c, 1'b0, 4, 2, 1'b0);
      addRow("badFcs", 36'd16, chanWord(8'hff, modeOr, 8'd9, 8'd9), bFcs,
             0, 8'h0c, 1'b0, 4, 2, 1'b0);
      addRow("badMac", 36'd16, chanWord(8'hff, modeOr, 8'd9, 8'd9), bMac,
             0, 8'h0c, 1'b0, 4, 2, 1'b0);
      addRow("badPort", 36'd16, chanWord(8'hff, modeOr, 8'd9, 8'd9), bPort,
             0, 8'h0c, 1'b0, 4, 2, 1'b0);
      addRow("badFlag", 36'd16, chanWord(8'hff, modeOr, 8'd9, 8'd9), bFlag,
             0, 8'h0c, 1'b0, 4, 2, 1'b0);
      addRow("rxErr", 36'd16, chanWord(8'hff, modeOr, 8'd9, 8'd9), bRxer,
             0, 8'h0c, 1'b0, 4, 2, 1'b0);
      addRow("ch2Or", 36'd18, chanWord(8'h80, modeOr, 8'd0, 8'd0), bNone,
             2, 8'h80, 1'b0, 2, 1, 1'b0);
      addRow("ch2Inv", 36'd0, 64'h4f, bNone,
             2, 8'h80, 1'b0, 2, 1, 1'b1);
      addRow("ch2Off", 36'd0, 64'h42, bNone,
             2, 8'h80, 1'b0, 2, 0, 1'b1);
      addRow("ch1Retrig", 36'd17, chanWord(8'h01, modeOr, 8'd4, 8'd3), bNone,
             1, 8'h01, 1'b1, 6, 4, 1'b0);
   endtask

   initial
   begin
      int limit;
      errCount       = 0;
      lcgState       = 32'hc44d_6c7e;
      rst            = 1'b1;
      PHY_RXD        = 8'h00;
      PHY_RXCTL_RXDV = 1'b0;
      PHY_RXER       = 1'b0;
      nimIn          = '0;
      buildTable();
      limit = 0;
      foreach (rows[i])
         limit += 72 + 20 + rows[i].expStart + rows[i].expLen + 10;
      fork
         begin
            #(2 * limit * 4);
            $display("watchdog timeout after %0d ns, the run did not finish", 2 * limit * 4);
            $display("tests failed");
            $finish;
         end
      join_none
      repeat (2) @(posedge PHY_RXCLK);
      #1;
      rst = 1'b0;
      // all registers cleared, so nothing may reach the outputs
      for (int n = 0; n < 16; n++)
      begin
         nimIn = nimIn_t'(randWord());
         @(posedge PHY_RXCLK);
         #1;
         checkNimOut("afterReset", '0, nimOut);
      end
      nimIn = '0;
      foreach (rows[i])
         runRow(rows[i]);
      $display("errors: %0d", errCount);
      if (errCount == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb.f ====
design/nimPkg.sv
design/chanCfgIf.sv
design/ethRxParser.sv
design/cfgRegs.sv
design/triggerChannel.sv
design/nimOutputStage.sv
design/nimTrigger.sv
testbench/nimTrigger_asserts.sv
testbench/tbNimTrigger.sv

// ==== run.sh ====
#!/bin/sh
# build and run the nimTrigger testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module tbNimTrigger -f tb.f -o simNimTrigger; then
   echo "verilator build failed"
   exit 1
fi

if ! out=$(./obj_dir/simNimTrigger); then
   echo "$out"
   echo "simulation exited with an error status"
   exit 1
fi
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
   exit 0
fi
exit 1
